//--- design/cpu_pkg.sv
package cpu_pkg;

  parameter int DW = 16;

  // Opcodes, upper nibble of the word
  parameter logic [3:0] OP_ADD = 4'h0;
  parameter logic [3:0] OP_SUB = 4'h1;
  parameter logic [3:0] OP_XOR = 4'h2;
  parameter logic [3:0] OP_SLL = 4'h4;
  parameter logic [3:0] OP_SRA = 4'h5;
  parameter logic [3:0] OP_LW  = 4'h8;
  parameter logic [3:0] OP_SW  = 4'h9;
  parameter logic [3:0] OP_LLB = 4'hA;
  parameter logic [3:0] OP_LHB = 4'hB;
  parameter logic [3:0] OP_B   = 4'hC;
  parameter logic [3:0] OP_HLT = 4'hF;

  // Branch conditions
  parameter logic [2:0] CC_NE = 3'b000;
  parameter logic [2:0] CC_EQ = 3'b001;
  parameter logic [2:0] CC_GT = 3'b010;
  parameter logic [2:0] CC_LT = 3'b011;
  parameter logic [2:0] CC_GE = 3'b100;
  parameter logic [2:0] CC_LE = 3'b101;
  parameter logic [2:0] CC_OV = 3'b110;
  parameter logic [2:0] CC_UN = 3'b111;

  // Operand source in EX
  parameter logic [1:0] FWD_REG = 2'd0;
  parameter logic [1:0] FWD_EX  = 2'd1;
  parameter logic [1:0] FWD_MEM = 2'd2;

  typedef union packed {
    struct packed {logic [3:0] opcode; logic [3:0] rd; logic [3:0] rs; logic [3:0] rt;} r_fmt;
    struct packed {logic [3:0] opcode; logic [3:0] rd; logic [7:0] imm8;} i_fmt;
    struct packed {logic [3:0] opcode; logic [2:0] ccc; logic [8:0] imm9;} b_fmt;
  } instr_t;

endpackage

//--- design/fwd_if.sv
`timescale 1ns/1ps

// Destination info of the two later pipeline registers
interface fwd_if;
  logic [3:0] exm_rd;
  logic       exm_wr;   // Valid and writes a register
  logic       exm_load;
  logic [3:0] mwb_rd;
  logic       mwb_wr;

  modport core (output exm_rd, exm_wr, exm_load, mwb_rd, mwb_wr);
  modport haz (input exm_rd, exm_wr, exm_load, mwb_rd, mwb_wr);
endinterface

//--- design/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic [3:0]             rs,
  input  logic [3:0]             rt,
  input  logic                   wr_en,
  input  logic [3:0]             wr_rd,
  input  logic [cpu_pkg::DW-1:0] wr_data,
  output logic [cpu_pkg::DW-1:0] rs_data,
  output logic [cpu_pkg::DW-1:0] rt_data
);
  logic [cpu_pkg::DW-1:0] regs [16];
  logic                   wr_ok;

  assign wr_ok = wr_en && (wr_rd != 4'd0); // R0 stays zero

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 16; i++) regs[i] <= '0;
    end else if (wr_ok) begin
      regs[wr_rd] <= wr_data;
    end
  end

  // Write before read
  assign rs_data = (wr_ok && wr_rd == rs) ? wr_data : regs[rs];
  assign rt_data = (wr_ok && wr_rd == rt) ? wr_data : regs[rt];

endmodule

//--- design/alu.sv
`timescale 1ns/1ps

module alu (
  input  logic [3:0]             opcode,
  input  logic [cpu_pkg::DW-1:0] a,
  input  logic [cpu_pkg::DW-1:0] b,
  output logic [cpu_pkg::DW-1:0] result,
  output logic                   flags_z,
  output logic                   flags_v,
  output logic                   flags_n
);
  import cpu_pkg::*;

  logic [DW-1:0] sum;
  logic [DW-1:0] diff;

  assign sum  = a + b;
  assign diff = a - b;

  always_comb begin
    case (opcode)
      OP_SUB:  result = diff;
      OP_XOR:  result = a ^ b;
      OP_SLL:  result = a << b[3:0];
      OP_SRA:  result = $signed(a) >>> b[3:0];
      OP_LLB:  result = {a[DW-1:8], b[7:0]};  // Keep high byte
      OP_LHB:  result = {b[7:0], a[7:0]};     // Keep low byte
      default: result = sum;                  // ADD, LW, SW address
    endcase
  end

  assign flags_z = (result == '0);
  assign flags_n = result[DW-1];

  // Signed overflow, no saturation
  always_comb begin
    case (opcode)
      OP_ADD:  flags_v = (a[DW-1] == b[DW-1]) && (sum[DW-1] != a[DW-1]);
      OP_SUB:  flags_v = (a[DW-1] != b[DW-1]) && (diff[DW-1] != a[DW-1]);
      default: flags_v = 1'b0;
    endcase
  end

endmodule

//--- design/decode_unit.sv
`timescale 1ns/1ps

module decode_unit (
  input  cpu_pkg::instr_t        instr,
  output logic [3:0]             rs,
  output logic [3:0]             rt,
  output logic [3:0]             rd,
  output logic                   reg_write,
  output logic                   mem_read,
  output logic                   mem_write,
  output logic                   is_branch,
  output logic                   is_halt,
  output logic                   uses_imm,
  output logic                   sets_flags,
  output logic [cpu_pkg::DW-1:0] imm
);
  import cpu_pkg::*;

  logic [3:0] op;

  assign op = instr.r_fmt.opcode;

  // Unused source registers decode as R0, so they never forward or stall
  always_comb begin
    rs         = 4'd0;
    rt         = 4'd0;
    rd         = instr.r_fmt.rd;
    reg_write  = 1'b0;
    mem_read   = 1'b0;
    mem_write  = 1'b0;
    is_branch  = 1'b0;
    is_halt    = 1'b0;
    uses_imm   = 1'b0;
    sets_flags = 1'b0;
    imm        = '0;
    case (op)
      OP_ADD, OP_SUB, OP_XOR: begin
        rs         = instr.r_fmt.rs;
        rt         = instr.r_fmt.rt;
        reg_write  = 1'b1;
        sets_flags = 1'b1;
      end
      OP_SLL, OP_SRA: begin
        rs        = instr.r_fmt.rs;
        reg_write = 1'b1;
        uses_imm  = 1'b1;
        imm       = {12'd0, instr.r_fmt.rt};  // Shift amount
      end
      OP_LW, OP_SW: begin
        rs        = instr.r_fmt.rs;
        uses_imm  = 1'b1;
        imm       = {{(DW-5){instr.r_fmt.rt[3]}}, instr.r_fmt.rt, 1'b0};
        reg_write = (op == OP_LW);
        mem_read  = (op == OP_LW);
        mem_write = (op == OP_SW);
        if (op == OP_SW) rt = instr.r_fmt.rd; // Store data
      end
      OP_LLB, OP_LHB: begin
        rs        = instr.i_fmt.rd;           // Other byte survives
        reg_write = 1'b1;
        uses_imm  = 1'b1;
        imm       = {8'd0, instr.i_fmt.imm8};
      end
      OP_B: begin
        is_branch = 1'b1;
        imm       = {{(DW-10){instr.b_fmt.imm9[8]}}, instr.b_fmt.imm9, 1'b0};
      end
      OP_HLT:  is_halt = 1'b1;
      default: ;                              // Unsupported opcodes act as NOP
    endcase
  end

endmodule

//--- design/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
  fwd_if.haz   fwd,
  input  logic [3:0] idex_rs,
  input  logic [3:0] idex_rt,
  input  logic [3:0] ifid_rs,
  input  logic [3:0] ifid_rt,
  input  logic [3:0] idex_rd,
  input  logic       idex_load,
  input  logic       branch_taken,
  output logic [1:0] sel_a,
  output logic [1:0] sel_b,
  output logic       stall,
  output logic       flush
);
  import cpu_pkg::*;

  logic ex_ok;
  logic mem_ok;

  // A load in MEM has no data yet, the stall covers that case
  assign ex_ok  = fwd.exm_wr && !fwd.exm_load && (fwd.exm_rd != 4'd0);
  assign mem_ok = fwd.mwb_wr && (fwd.mwb_rd != 4'd0);

  always_comb begin
    sel_a = FWD_REG;
    sel_b = FWD_REG;
    if (ex_ok && fwd.exm_rd == idex_rs)       sel_a = FWD_EX;
    else if (mem_ok && fwd.mwb_rd == idex_rs) sel_a = FWD_MEM;
    if (ex_ok && fwd.exm_rd == idex_rt)       sel_b = FWD_EX;
    else if (mem_ok && fwd.mwb_rd == idex_rt) sel_b = FWD_MEM;
  end

  // Load-use, one bubble
  assign stall = idex_load && (idex_rd != 4'd0) &&
                 ((idex_rd == ifid_rs) || (idex_rd == ifid_rt));

  assign flush = branch_taken; // IF/ID and ID/EX

endmodule

//--- design/mem_array.sv
`timescale 1ns/1ps

module mem_array #(
  parameter int AW = 8
) (
  input  logic                   clk,
  input  logic                   we,
  input  logic [AW-1:0]          waddr,
  input  logic [cpu_pkg::DW-1:0] wdata,
  input  logic [AW-1:0]          raddr,
  output logic [cpu_pkg::DW-1:0] rdata
);
  logic [cpu_pkg::DW-1:0] mem [2**AW];

  always_ff @(posedge clk) begin
    if (we) mem[waddr] <= wdata;
  end

  assign rdata = mem[raddr]; // Same-cycle read

endmodule

//--- design/cpu_core.sv
`timescale 1ns/1ps

module cpu_core #(
  parameter int IMEM_AW = 8,
  parameter int DMEM_AW = 8
) (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   run,
  input  logic [cpu_pkg::DW-1:0] imem_rdata,
  input  logic [cpu_pkg::DW-1:0] dmem_rdata,
  output logic [IMEM_AW-1:0]     imem_addr,
  output logic [DMEM_AW-1:0]     dmem_addr,
  output logic                   dmem_we,
  output logic [cpu_pkg::DW-1:0] dmem_wdata,
  output logic                   hlt,
  output logic [cpu_pkg::DW-1:0] pc_out,
  output logic                   wb_valid,
  output logic [3:0]             wb_rd,
  output logic [cpu_pkg::DW-1:0] wb_data
);
  import cpu_pkg::*;

  fwd_if fwd ();

  logic [DW-1:0] pc, pc2;
  logic          halt_seen, hlt_q, stall, flush, fetch_ok;
  logic [2:0]    flags;                        // Z, V, N
  // IF/ID
  logic          ifid_valid;
  instr_t        ifid_instr;
  logic [DW-1:0] ifid_pc2;
  // Decode outputs
  logic [3:0]    d_rs, d_rt, d_rd;
  logic          d_wr, d_mrd, d_mwr, d_br, d_hlt, d_imm, d_flg;
  logic [DW-1:0] d_immv, rs_data, rt_data;
  // ID/EX
  logic          idex_valid, idex_wr, idex_mrd, idex_mwr, idex_br, idex_hlt, idex_uimm, idex_flg;
  logic [3:0]    idex_rs, idex_rt, idex_rd, idex_op;
  logic [2:0]    idex_ccc;
  logic [DW-1:0] idex_a, idex_b, idex_imm, idex_pc2;
  // EX stage
  logic [1:0]    sel_a, sel_b;
  logic [DW-1:0] op_a, op_b, alu_res;
  logic          alu_z, alu_v, alu_n, cond, branch_taken;
  // EX/MEM and MEM/WB
  logic          exm_valid, exm_wr, exm_mrd, exm_mwr, exm_hlt;
  logic [3:0]    exm_rd;
  logic [DW-1:0] exm_alu, exm_store;
  logic          mwb_valid, mwb_wr, mwb_load, mwb_hlt;
  logic [3:0]    mwb_rd;
  logic [DW-1:0] mwb_alu, mwb_mem;

  ////////////////////////////////////////////////////////////
  // Fetch
  ////////////////////////////////////////////////////////////
  assign pc2       = pc + 16'd2;
  assign imem_addr = pc[IMEM_AW:1];
  assign pc_out    = pc;
  // HLT in decode stops fetch unless it is being squashed
  assign fetch_ok  = run && !halt_seen && !(ifid_valid && d_hlt);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc         <= '0;
      ifid_valid <= 1'b0;
      halt_seen  <= 1'b0;
    end else begin
      if (branch_taken)               pc <= idex_pc2 + idex_imm;
      else if (fetch_ok && !stall)    pc <= pc2;
      if (flush)       ifid_valid <= 1'b0;
      else if (!stall) ifid_valid <= fetch_ok;
      if (ifid_valid && d_hlt && !flush) halt_seen <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      ifid_instr <= imem_rdata;
      ifid_pc2   <= pc2;
    end
  end

  ////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////
  decode_unit dec_i (
    .instr(ifid_instr), .rs(d_rs), .rt(d_rt), .rd(d_rd), .reg_write(d_wr),
    .mem_read(d_mrd), .mem_write(d_mwr), .is_branch(d_br), .is_halt(d_hlt),
    .uses_imm(d_imm), .sets_flags(d_flg), .imm(d_immv)
  );

  reg_file rf_i (
    .clk(clk), .arst_n(arst_n), .rs(d_rs), .rt(d_rt), .wr_en(wb_valid),
    .wr_rd(wb_rd), .wr_data(wb_data), .rs_data(rs_data), .rt_data(rt_data)
  );

  hazard_unit haz_i (
    .fwd(fwd.haz), .idex_rs(idex_rs), .idex_rt(idex_rt),
    .ifid_rs(ifid_valid ? d_rs : 4'd0), .ifid_rt(ifid_valid ? d_rt : 4'd0),
    .idex_rd(idex_rd), .idex_load(idex_valid && idex_mrd), .branch_taken(branch_taken),
    .sel_a(sel_a), .sel_b(sel_b), .stall(stall), .flush(flush)
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) idex_valid <= 1'b0;
    else         idex_valid <= ifid_valid && !stall && !flush; // Bubble on stall
  end

  always_ff @(posedge clk) begin
    {idex_rs, idex_rt, idex_rd, idex_op} <= {d_rs, d_rt, d_rd, ifid_instr.r_fmt.opcode};
    {idex_wr, idex_mrd, idex_mwr, idex_br} <= {d_wr, d_mrd, d_mwr, d_br};
    {idex_hlt, idex_uimm, idex_flg}        <= {d_hlt, d_imm, d_flg};
    idex_ccc <= ifid_instr.b_fmt.ccc;
    idex_a   <= rs_data;
    idex_b   <= rt_data;
    idex_imm <= d_immv;
    idex_pc2 <= ifid_pc2;
  end

  ////////////////////////////////////////////////////////////
  // Execute
  ////////////////////////////////////////////////////////////
  assign op_a = (sel_a == FWD_EX) ? exm_alu : (sel_a == FWD_MEM) ? wb_data : idex_a;
  assign op_b = (sel_b == FWD_EX) ? exm_alu : (sel_b == FWD_MEM) ? wb_data : idex_b;

  alu alu_i (
    .opcode(idex_op), .a(op_a), .b(idex_uimm ? idex_imm : op_b), .result(alu_res),
    .flags_z(alu_z), .flags_v(alu_v), .flags_n(alu_n)
  );

  always_comb begin
    case (idex_ccc)
      CC_NE:   cond = !flags[2];
      CC_EQ:   cond = flags[2];
      CC_GT:   cond = !flags[2] && !flags[0];
      CC_LT:   cond = flags[0];
      CC_GE:   cond = flags[2] || !flags[0];
      CC_LE:   cond = flags[2] || flags[0];
      CC_OV:   cond = flags[1];
      default: cond = 1'b1;                    // Unconditional
    endcase
  end
  assign branch_taken = idex_valid && idex_br && cond;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      flags     <= '0;
      exm_valid <= 1'b0;
      mwb_valid <= 1'b0;
      hlt_q     <= 1'b0;
    end else begin
      if (idex_valid && idex_flg) flags <= {alu_z, alu_v, alu_n};
      exm_valid <= idex_valid;
      mwb_valid <= exm_valid;
      if (mwb_valid && mwb_hlt) hlt_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    {exm_wr, exm_mrd, exm_mwr, exm_hlt} <= {idex_wr, idex_mrd, idex_mwr, idex_hlt};
    exm_rd    <= idex_rd;
    exm_alu   <= alu_res;
    exm_store <= op_b;                         // Forwarded store data
    {mwb_wr, mwb_load, mwb_hlt} <= {exm_wr, exm_mrd, exm_hlt};
    mwb_rd  <= exm_rd;
    mwb_alu <= exm_alu;
    mwb_mem <= dmem_rdata;
  end

  ////////////////////////////////////////////////////////////
  // Memory and writeback
  ////////////////////////////////////////////////////////////
  assign dmem_addr  = exm_alu[DMEM_AW:1];
  assign dmem_we    = exm_valid && exm_mwr;
  assign dmem_wdata = exm_store;

  assign wb_valid = mwb_valid && mwb_wr;
  assign wb_rd    = mwb_rd;
  assign wb_data  = mwb_load ? mwb_mem : mwb_alu;
  assign hlt      = hlt_q || (mwb_valid && mwb_hlt);

  assign fwd.exm_rd   = exm_rd;
  assign fwd.exm_wr   = exm_valid && exm_wr;
  assign fwd.exm_load = exm_mrd;
  assign fwd.mwb_rd   = mwb_rd;
  assign fwd.mwb_wr   = wb_valid;

endmodule

//--- design/cpu.sv
`timescale 1ns/1ps

module cpu #(
  parameter int IMEM_AW = 8,
  parameter int DMEM_AW = 8
) (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   run,
  input  logic                   prog_we,
  input  logic [IMEM_AW-1:0]     prog_addr,   // Word index
  input  logic [cpu_pkg::DW-1:0] prog_data,
  output logic                   hlt,
  output logic [cpu_pkg::DW-1:0] pc_out,
  output logic                   wb_valid,
  output logic [3:0]             wb_rd,
  output logic [cpu_pkg::DW-1:0] wb_data
);
  logic [IMEM_AW-1:0]     imem_addr;
  logic [DMEM_AW-1:0]     dmem_addr;
  logic                   dmem_we;
  logic [cpu_pkg::DW-1:0] imem_rdata, dmem_rdata, dmem_wdata;

  cpu_core #(.IMEM_AW(IMEM_AW), .DMEM_AW(DMEM_AW)) core_i (
    .clk(clk), .arst_n(arst_n), .run(run), .imem_rdata(imem_rdata),
    .dmem_rdata(dmem_rdata), .imem_addr(imem_addr), .dmem_addr(dmem_addr),
    .dmem_we(dmem_we), .dmem_wdata(dmem_wdata), .hlt(hlt), .pc_out(pc_out),
    .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
  );

  mem_array #(.AW(IMEM_AW)) imem_i (
    .clk(clk), .we(prog_we), .waddr(prog_addr), .wdata(prog_data),
    .raddr(imem_addr), .rdata(imem_rdata)
  );

  mem_array #(.AW(DMEM_AW)) dmem_i (
    .clk(clk), .we(dmem_we), .waddr(dmem_addr), .wdata(dmem_wdata),
    .raddr(dmem_addr), .rdata(dmem_rdata)
  );

endmodule

//--- include/isa_model.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// Instruction-at-a-time model of the core
logic [15:0]     model_regs [16];
logic [15:0]     model_dmem [256];
cpu_pkg::instr_t model_imem [256];
logic [15:0]     model_pc;
logic            model_z;
logic            model_v;
logic            model_n;
bit              model_halted;

function automatic void reset_model();
  for (int k = 0; k < 16; k++) model_regs[k] = '0;
  for (int k = 0; k < 256; k++) model_dmem[k] = '0;
  model_pc = '0;
  model_z = 1'b0;
  model_v = 1'b0;
  model_n = 1'b0;
  model_halted = 1'b0;
endfunction

// One instruction, reports the register write if any
function automatic bit step_model(output logic [3:0] rd, output logic [15:0] data);
  cpu_pkg::instr_t i;
  logic [15:0]     a;
  logic [15:0]     b;
  logic [15:0]     r;
  logic [15:0]     ea;
  bit              take;
  bit              wr;
  i = model_imem[model_pc[8:1]];
  a = model_regs[i.r_fmt.rs];
  b = model_regs[i.r_fmt.rt];
  rd = i.r_fmt.rd;
  wr = 1'b1;
  r = '0;
  take = 1'b0;
  model_pc = model_pc + 16'd2;
  ea = a + {{11{i.r_fmt.rt[3]}}, i.r_fmt.rt, 1'b0};
  case (i.r_fmt.opcode)
    4'h0: begin
      r = a + b;
      model_v = (a[15] == b[15]) && (r[15] != a[15]);
    end
    4'h1: begin
      r = a - b;
      model_v = (a[15] != b[15]) && (r[15] != a[15]);
    end
    4'h2: begin
      r = a ^ b;
      model_v = 1'b0;
    end
    4'h4: r = a << i.r_fmt.rt;
    4'h5: r = $signed(a) >>> i.r_fmt.rt;
    4'h8: r = model_dmem[ea[8:1]];
    4'h9: begin
      model_dmem[ea[8:1]] = model_regs[rd];
      wr = 1'b0;
    end
    4'hA: r = {model_regs[rd][15:8], i.i_fmt.imm8};
    4'hB: r = {i.i_fmt.imm8, model_regs[rd][7:0]};
    4'hC: begin
      case (i.b_fmt.ccc)
        3'd0: take = !model_z;
        3'd1: take = model_z;
        3'd2: take = !model_z && !model_n;
        3'd3: take = model_n;
        3'd4: take = model_z || !model_n;
        3'd5: take = model_z || model_n;
        3'd6: take = model_v;
        default: take = 1'b1;
      endcase
      if (take) model_pc = model_pc + {{6{i.b_fmt.imm9[8]}}, i.b_fmt.imm9, 1'b0};
      wr = 1'b0;
    end
    4'hF: begin
      model_halted = 1'b1;
      model_pc = model_pc - 16'd2;
      wr = 1'b0;
    end
    default: wr = 1'b0;
  endcase
  if (i.r_fmt.opcode <= 4'h2) begin
    model_z = (r == 16'd0);
    model_n = r[15];
  end
  if (wr && rd != 4'd0) model_regs[rd] = r;
  data = r;
  return wr;
endfunction

`endif

//--- dv/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;
  import cpu_pkg::*;

  localparam int MAX_CYCLES = 3000;
  localparam int BODY_LEN   = 30;

  logic          clk;
  logic          arst_n;
  logic          run;
  logic          prog_we;
  logic [7:0]    prog_addr;
  logic [DW-1:0] prog_data;
  logic          hlt;
  logic [DW-1:0] pc_out;
  logic          wb_valid;
  logic [3:0]    wb_rd;
  logic [DW-1:0] wb_data;

  logic [15:0] lfsr;
  logic [15:0] prog [256];
  int          prog_len;
  string       cur_test;
  int          errors;
  int          retires;
  int          n_pass;
  int          n_fail;
  bit          timed_out;

  `include "isa_model.svh"

  cpu #(.IMEM_AW(8), .DMEM_AW(8)) dut_i (
    .clk(clk), .arst_n(arst_n), .run(run), .prog_we(prog_we), .prog_addr(prog_addr),
    .prog_data(prog_data), .hlt(hlt), .pc_out(pc_out), .wb_valid(wb_valid),
    .wb_rd(wb_rd), .wb_data(wb_data)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Random numbers and program generation
  ////////////////////////////////////////////////////////////
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      r = {r[14:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1); // Galois step
    end
    return r;
  endfunction

  function automatic logic [3:0] rand_dest();
    logic [3:0] r;
    r = 4'(rand_bits(4));
    if (r > 4'd12) r = r - 4'd12;  // R13 and R14 hold memory bases
    return r;
  endfunction

  task automatic emit(input logic [15:0] word);
    prog[prog_len] = word;
    prog_len++;
  endtask

  task automatic emit_alu(input logic [3:0] rd, input logic [3:0] rs);
    logic [3:0] op;
    logic [3:0] rt;
    rt = 4'(rand_bits(4));
    case (rand_bits(2))
      16'd0:   op = OP_ADD;
      16'd1:   op = OP_SUB;
      16'd2:   op = OP_XOR;
      default: op = rand_bits(1) ? OP_SLL : OP_SRA;
    endcase
    emit({op, rd, rs, rt});
  endtask

  // Word 0..15 off R13, word 16..31 off R14
  task automatic emit_mem(input logic load, input logic [3:0] rd, input logic [4:0] where);
    emit({load ? OP_LW : OP_SW, rd, where[4] ? 4'd14 : 4'd13, where[3:0]});
  endtask

  // Forward branch over 0 to 3 filler ops
  task automatic emit_branch(input logic [2:0] cc);
    logic [1:0] skip;
    skip = 2'(rand_bits(2));
    emit({OP_B, cc, 7'd0, skip});
    for (int k = 0; k < skip; k++) emit_alu(rand_dest(), 4'(rand_bits(4)));
  endtask

  task automatic gen_program(input int kind);
    logic [3:0] last;
    logic [3:0] r;
    logic [4:0] where;
    prog_len = 0;
    emit({OP_LLB, 4'd13, 8'h10});
    emit({OP_LLB, 4'd14, 8'h30});
    for (int k = 0; k < 16; k++) begin  // Clear data words 0..31
      emit({OP_SW, 4'd0, 4'd13, 4'(k - 8)});
      emit({OP_SW, 4'd0, 4'd14, 4'(k - 8)});
    end
    for (int k = 1; k <= 12; k++) begin
      emit({OP_LLB, 4'(k), 8'(rand_bits(8))});
      emit({OP_LHB, 4'(k), 8'(rand_bits(8))});
    end
    last = 4'd1;
    for (int k = 0; k < BODY_LEN; k++) begin
      r = rand_dest();
      where = 5'(rand_bits(5));
      case (kind)
        1: begin                        // Dependent chain, store after write
          emit_alu(r, last);
          if (k % 4 == 3) begin
            emit_mem(1'b0, r, where);
            emit_mem(1'b1, rand_dest(), where);
          end
        end
        2: begin                        // Load then use
          emit_mem(1'b0, 4'(rand_bits(4)), where);
          emit_mem(1'b1, r, where);
          emit_alu(rand_dest(), r);
        end
        3: begin
          emit_alu(r, last);
          emit_branch(3'(k % 8));
        end
        default: begin
          case (rand_bits(3))
            16'd4:   emit_mem(1'b1, r, where);
            16'd5:   emit_mem(1'b0, 4'(rand_bits(4)), where);
            16'd6:   emit_branch(3'(rand_bits(3)));
            16'd7:   emit({rand_bits(1) ? OP_LHB : OP_LLB, r, 8'(rand_bits(8))});
            default: emit_alu(r, 4'(rand_bits(4)));
          endcase
        end
      endcase
      last = r;
    end
    emit({OP_HLT, 12'h000});
  endtask

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////
  task automatic check_word(input string what, input logic [DW-1:0] exp,
                            input logic [DW-1:0] act);
    if (act !== exp) begin
      $display("Error %s %s: expected %h, actual %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_reg(input string what, input logic [3:0] exp, input logic [3:0] act);
    if (act !== exp) begin
      $display("Error %s %s: expected R%0d, actual R%0d", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Error %s %s: expected %b, actual %b", cur_test, what, exp, act);
      errors++;
    end
  endtask

  // Step the model to its next register write and compare
  task automatic compare_retire();
    logic [3:0]  rd;
    logic [15:0] data;
    bit          wr;
    int          guard;
    wr = 1'b0;
    guard = 0;
    while (!wr && !model_halted && guard < 1000) begin
      wr = step_model(rd, data);
      guard++;
    end
    retires++;
    if (!wr) begin
      $display("%s: DUT retired R%0d after the program's last write", cur_test, wb_rd);
      errors++;
    end else begin
      check_reg($sformatf("retire %0d rd", retires), rd, wb_rd);
      check_word($sformatf("retire %0d data", retires), data, wb_data);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Sequencing
  ////////////////////////////////////////////////////////////
  task automatic pulse_reset();
    @(posedge clk);
    #5 arst_n = 1'b0;
    repeat (8) @(posedge clk);
    #5 arst_n = 1'b1;
  endtask

  task automatic load_program();
    for (int k = 0; k < prog_len; k++) begin
      @(posedge clk);
      #5;
      prog_we   = 1'b1;
      prog_addr = 8'(k);
      prog_data = prog[k];
    end
    @(posedge clk);
    #5 prog_we = 1'b0;
  endtask

  task automatic finish_test();
    $display("%s: %0d retires, %0d errors", cur_test, retires, errors);
    if (errors == 0) n_pass++;
    else n_fail++;
  endtask

  task automatic run_low_test();
    cur_test = "run_low";
    errors = 0;
    retires = 0;
    run = 1'b0;
    pulse_reset();
    repeat (16) begin
      @(negedge clk);
      check_bit("wb_valid", 1'b0, wb_valid);
      check_bit("hlt", 1'b0, hlt);
      check_word("pc_out", 16'h0000, pc_out);
    end
    finish_test();
  endtask

  task automatic run_program(input string name, input int kind);
    logic [3:0]  rd;
    logic [15:0] data;
    int          cycles;
    int          guard;
    cur_test = name;
    errors = 0;
    retires = 0;
    @(posedge clk);
    #5 run = 1'b0;
    pulse_reset();
    gen_program(kind);
    reset_model();
    for (int k = 0; k < 256; k++) model_imem[k] = (k < prog_len) ? prog[k] : 16'hF000;
    load_program();
    @(posedge clk);
    #5 run = 1'b1;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (wb_valid) compare_retire();
    end while (!hlt && cycles < MAX_CYCLES);
    if (!hlt) begin
      $display("%s: hlt did not rise within %0d cycles", name, MAX_CYCLES);
      timed_out = 1'b1;
      errors++;
    end else begin
      guard = 0;
      while (!model_halted && guard < 1000) begin  // Nothing may be left
        if (step_model(rd, data)) begin
          $display("%s: hlt rose before the write of R%0d retired", name, rd);
          errors++;
        end
        guard++;
      end
      repeat (8) begin
        @(negedge clk);
        check_bit("hlt held", 1'b1, hlt);
        check_bit("wb_valid after hlt", 1'b0, wb_valid);
        check_word("pc_out after hlt", model_pc + 16'd2, pc_out);
      end
    end
    finish_test();
  endtask

  initial begin
    arst_n    = 1'b0;
    run       = 1'b0;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    lfsr      = 16'd60205;
    n_pass    = 0;
    n_fail    = 0;
    timed_out = 1'b0;
    run_low_test();
    for (int t = 0; t < 12 && !timed_out; t++) begin
      case (t)
        0, 1:    run_program($sformatf("fwd_chain_%0d", t), 1);
        2, 3:    run_program($sformatf("load_use_%0d", t - 2), 2);
        4, 5:    run_program($sformatf("branch_cc_%0d", t - 4), 3);
        default: run_program($sformatf("random_%0d", t - 6), 0);
      endcase
    end
    $display("Tests: %0d passed, %0d failed", n_pass, n_fail);
    if (n_fail == 0 && !timed_out) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+include
design/cpu_pkg.sv
design/fwd_if.sv
design/reg_file.sv
design/alu.sv
design/decode_unit.sv
design/hazard_unit.sv
design/mem_array.sv
design/cpu_core.sv
design/cpu.sv
dv/cpu_tb.sv
